// ==== src/mipsPkg.sv ====
package mipsPkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [3:0]  aluOp_t;

  // Queue and credit sizing
  localparam int QueueDepth   = 4;
  localparam int ResCreditMax = 4;

  typedef logic [$clog2(QueueDepth)-1:0]   queuePtr_t;
  typedef logic [$clog2(QueueDepth+1)-1:0] queueCount_t;
  typedef logic [$clog2(ResCreditMax+1)-1:0] credit_t;

  ////////////////////////////////////////
  // ALU operation codes
  ////////////////////////////////////////

  localparam aluOp_t AluAdd = 4'd0;
  localparam aluOp_t AluSub = 4'd1;
  localparam aluOp_t AluAnd = 4'd2;
  localparam aluOp_t AluOr  = 4'd3;
  localparam aluOp_t AluSlt = 4'd4;
  localparam aluOp_t AluSll = 4'd5;
  localparam aluOp_t AluSrl = 4'd6;
  localparam aluOp_t AluLui = 4'd7;

  // Primary opcodes
  localparam logic [5:0] OpRType = 6'h00;
  localparam logic [5:0] OpAddi  = 6'h08;
  localparam logic [5:0] OpAndi  = 6'h0c;
  localparam logic [5:0] OpOri   = 6'h0d;
  localparam logic [5:0] OpLui   = 6'h0f;

  // R-type funct field
  localparam logic [5:0] FnSll = 6'h00;
  localparam logic [5:0] FnSrl = 6'h02;
  localparam logic [5:0] FnAdd = 6'h20;
  localparam logic [5:0] FnSub = 6'h22;
  localparam logic [5:0] FnAnd = 6'h24;
  localparam logic [5:0] FnOr  = 6'h25;
  localparam logic [5:0] FnSlt = 6'h2a;

endpackage

// ==== src/decodeExIf.sv ====
interface decodeExIf;

  // Decode side, driven by the decoder
  logic              validD, regWriteD, aluSrcD;
  mipsPkg::aluOp_t   aluOpD;
  mipsPkg::regIdx_t  writeRegD;
  mipsPkg::shamt_t   shamtD;
  mipsPkg::word_t    readData1D, readData2D, immExtD, pcD;

  // Execute side, held in the stage register
  logic              validE, regWriteE, aluSrcE;
  mipsPkg::aluOp_t   aluOpE;
  mipsPkg::regIdx_t  writeRegE;
  mipsPkg::shamt_t   shamtE;
  mipsPkg::word_t    readData1E, readData2E, immExtE, pcE;

  modport issue (output validD, regWriteD, aluSrcD, aluOpD, writeRegD, shamtD,
                        readData1D, readData2D, immExtD, pcD,
                 input  validE, regWriteE, writeRegE);
  modport stage (input  validD, regWriteD, aluSrcD, aluOpD, writeRegD, shamtD,
                        readData1D, readData2D, immExtD, pcD,
                 output validE, regWriteE, aluSrcE, aluOpE, writeRegE, shamtE,
                        readData1E, readData2E, immExtE, pcE);
  modport exec  (input  validE, regWriteE, aluSrcE, aluOpE, writeRegE, shamtE,
                        readData1E, readData2E, immExtE, pcE);

endinterface

// ==== src/instrQueue.sv ====
module instrQueue (
  input  logic           Clk,
  input  logic           rst,
  input  logic           instrValid,
  input  mipsPkg::word_t instr,
  input  mipsPkg::word_t instrPc,
  input  logic           pop,
  output logic           headValid,
  output mipsPkg::word_t headInstr,
  output mipsPkg::word_t headPc,
  output logic           instrCredit
);

  mipsPkg::word_t         instrMem [mipsPkg::QueueDepth];
  mipsPkg::word_t         pcMem [mipsPkg::QueueDepth];
  mipsPkg::queuePtr_t     wrPtr, rdPtr;
  mipsPkg::queueCount_t   count;
  logic                   push, popOk;

  // Upstream only sends with a credit, full check is a safety net
  assign push  = instrValid && (count != mipsPkg::queueCount_t'(mipsPkg::QueueDepth));
  assign popOk = pop && headValid;

  assign headValid = (count != '0);
  assign headInstr = instrMem[rdPtr];
  assign headPc    = pcMem[rdPtr];

  // Entry storage
  always_ff @(posedge Clk) begin
    if (push) begin
      instrMem[wrPtr] <= instr;
      pcMem[wrPtr]    <= instrPc;
    end
  end

  // Pointers, occupancy and credit return
  always_ff @(posedge Clk) begin
    if (rst) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      instrCredit <= 1'b0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;
      if (popOk) rdPtr <= rdPtr + 1'b1;
      case ({push, popOk})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      instrCredit <= popOk;
    end
  end

endmodule

// ==== src/instrDecoder.sv ====
module instrDecoder (
  input  logic             Clk,
  input  logic             rst,
  input  logic             headValid,
  input  mipsPkg::word_t   headInstr,
  input  mipsPkg::word_t   headPc,
  output logic             pop,
  input  logic             advance,
  input  logic             wbEn,
  input  mipsPkg::regIdx_t wbReg,
  input  mipsPkg::word_t   wbData,
  decodeExIf.issue         dx
);

  logic [5:0]       opcode, funct;
  logic [15:0]      imm;
  mipsPkg::regIdx_t rs, rt, rd;
  mipsPkg::word_t   regFile [32];
  logic             usesRt, hazard;

  assign opcode = headInstr[31:26];
  assign rs     = headInstr[25:21];
  assign rt     = headInstr[20:16];
  assign rd     = headInstr[15:11];
  assign funct  = headInstr[5:0];
  assign imm    = headInstr[15:0];

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regFile[i] <= '0;
      end
    end else if (wbEn && (wbReg != '0)) begin
      regFile[wbReg] <= wbData;
    end
  end

  // r0 always reads zero
  assign dx.readData1D = (rs == '0) ? '0 : regFile[rs];
  assign dx.readData2D = (rt == '0) ? '0 : regFile[rt];
  assign dx.shamtD     = headInstr[10:6];
  assign dx.pcD        = headPc;

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////

  always_comb begin
    dx.regWriteD = 1'b0;
    dx.aluSrcD   = 1'b0;
    dx.aluOpD    = mipsPkg::AluAdd;
    dx.writeRegD = '0;
    dx.immExtD   = '0;
    case (opcode)
      mipsPkg::OpRType: begin
        dx.regWriteD = 1'b1;
        dx.writeRegD = rd;
        case (funct)
          mipsPkg::FnAdd: dx.aluOpD = mipsPkg::AluAdd;
          mipsPkg::FnSub: dx.aluOpD = mipsPkg::AluSub;
          mipsPkg::FnAnd: dx.aluOpD = mipsPkg::AluAnd;
          mipsPkg::FnOr:  dx.aluOpD = mipsPkg::AluOr;
          mipsPkg::FnSlt: dx.aluOpD = mipsPkg::AluSlt;
          mipsPkg::FnSll: dx.aluOpD = mipsPkg::AluSll;
          mipsPkg::FnSrl: dx.aluOpD = mipsPkg::AluSrl;
          default: begin
            // Unknown funct retires as an empty record
            dx.regWriteD = 1'b0;
            dx.writeRegD = '0;
          end
        endcase
      end
      mipsPkg::OpAddi: begin
        dx.regWriteD = 1'b1;
        dx.aluSrcD   = 1'b1;
        dx.writeRegD = rt;
        dx.immExtD   = {{16{imm[15]}}, imm};
      end
      mipsPkg::OpAndi: begin
        dx.regWriteD = 1'b1;
        dx.aluSrcD   = 1'b1;
        dx.aluOpD    = mipsPkg::AluAnd;
        dx.writeRegD = rt;
        dx.immExtD   = {16'h0000, imm};
      end
      mipsPkg::OpOri: begin
        dx.regWriteD = 1'b1;
        dx.aluSrcD   = 1'b1;
        dx.aluOpD    = mipsPkg::AluOr;
        dx.writeRegD = rt;
        dx.immExtD   = {16'h0000, imm};
      end
      mipsPkg::OpLui: begin
        dx.regWriteD = 1'b1;
        dx.aluSrcD   = 1'b1;
        dx.aluOpD    = mipsPkg::AluLui;
        dx.writeRegD = rt;
        dx.immExtD   = {imm, 16'h0000};
      end
      default: ;
    endcase
  end

  // Stall one cycle while the execute stage still owes a source register
  assign usesRt = (opcode == mipsPkg::OpRType);
  assign hazard = dx.validE && dx.regWriteE && (dx.writeRegE != '0) &&
                  ((dx.writeRegE == rs) || (usesRt && (dx.writeRegE == rt)));

  assign pop       = headValid && !hazard && advance;
  assign dx.validD = pop;

endmodule

// ==== src/decodeExReg.sv ====
module decodeExReg (
  input  logic     Clk,
  input  logic     rst,
  input  logic     advance,
  decodeExIf.stage dx
);

  ////////////////////////////////////////
  // Decode/execute boundary
  ////////////////////////////////////////

  // Advance with nothing issued inserts a bubble, otherwise hold
  always_ff @(posedge Clk) begin
    if (rst || (advance && !dx.validD)) begin
      dx.validE     <= 1'b0;
      dx.regWriteE  <= 1'b0;
      dx.aluSrcE    <= 1'b0;
      dx.aluOpE     <= '0;
      dx.writeRegE  <= '0;
      dx.shamtE     <= '0;
      dx.readData1E <= '0;
      dx.readData2E <= '0;
      dx.immExtE    <= '0;
      dx.pcE        <= '0;
    end else if (advance) begin
      dx.validE     <= 1'b1;
      dx.regWriteE  <= dx.regWriteD;
      dx.aluSrcE    <= dx.aluSrcD;
      dx.aluOpE     <= dx.aluOpD;
      dx.writeRegE  <= dx.writeRegD;
      dx.shamtE     <= dx.shamtD;
      dx.readData1E <= dx.readData1D;
      dx.readData2E <= dx.readData2D;
      dx.immExtE    <= dx.immExtD;
      dx.pcE        <= dx.pcD;
    end
  end

endmodule

// ==== src/aluExecute.sv ====
module aluExecute (
  input  logic             Clk,
  input  logic             rst,
  decodeExIf.exec          dx,
  input  logic             resCredit,
  output logic             advance,
  output logic             wbEn,
  output mipsPkg::regIdx_t wbReg,
  output mipsPkg::word_t   wbData,
  output logic             resValid,
  output mipsPkg::regIdx_t resDest,
  output mipsPkg::word_t   resData,
  output mipsPkg::word_t   resPc
);

  mipsPkg::credit_t creditCnt;
  mipsPkg::word_t   srcB, result;
  logic             fire;

  // Stage may move when empty or when the downstream has room
  assign advance = !dx.validE || (creditCnt != '0);
  assign fire    = dx.validE && advance;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  assign srcB = dx.aluSrcE ? dx.immExtE : dx.readData2E;

  always_comb begin
    case (dx.aluOpE)
      mipsPkg::AluAdd: result = dx.readData1E + srcB;
      mipsPkg::AluSub: result = dx.readData1E - srcB;
      mipsPkg::AluAnd: result = dx.readData1E & srcB;
      mipsPkg::AluOr:  result = dx.readData1E | srcB;
      mipsPkg::AluSlt: result = {31'b0, $signed(dx.readData1E) < $signed(srcB)};
      mipsPkg::AluSll: result = srcB << dx.shamtE;
      mipsPkg::AluSrl: result = srcB >> dx.shamtE;
      // Immediate arrives already shifted
      mipsPkg::AluLui: result = srcB;
      default:         result = '0;
    endcase
  end

  // Write-back lands on the same edge the record is registered
  assign wbEn   = fire && dx.regWriteE;
  assign wbReg  = dx.writeRegE;
  assign wbData = result;

  // Downstream credits, spend and return may coincide
  always_ff @(posedge Clk) begin
    if (rst) begin
      creditCnt <= mipsPkg::credit_t'(mipsPkg::ResCreditMax);
    end else begin
      case ({fire, resCredit})
        2'b10:   creditCnt <= creditCnt - 1'b1;
        2'b01:   creditCnt <= creditCnt + 1'b1;
        default: creditCnt <= creditCnt;
      endcase
    end
  end

  ////////////////////////////////////////
  // Result record
  ////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (rst) begin
      resValid <= 1'b0;
    end else begin
      resValid <= fire;
    end
  end

  always_ff @(posedge Clk) begin
    if (fire) begin
      resDest <= dx.regWriteE ? dx.writeRegE : '0;
      resData <= dx.regWriteE ? result : '0;
      resPc   <= dx.pcE;
    end
  end

endmodule

// ==== src/decodeExecTop.sv ====
module decodeExecTop (
  input  logic             Clk,
  input  logic             rst,
  // Instruction input
  input  logic             instrValid,
  input  mipsPkg::word_t   instr,
  input  mipsPkg::word_t   instrPc,
  output logic             instrCredit,
  // Result output
  output logic             resValid,
  output mipsPkg::regIdx_t resDest,
  output mipsPkg::word_t   resData,
  output mipsPkg::word_t   resPc,
  input  logic             resCredit
);

  logic             pop, headValid, advance, wbEn;
  mipsPkg::word_t   headInstr, headPc, wbData;
  mipsPkg::regIdx_t wbReg;

  decodeExIf dx ();

  instrQueue queue0 (
    .Clk(Clk), .rst(rst), .instrValid(instrValid), .instr(instr), .instrPc(instrPc),
    .pop(pop), .headValid(headValid), .headInstr(headInstr), .headPc(headPc),
    .instrCredit(instrCredit)
  );

  instrDecoder decoder0 (
    .Clk(Clk), .rst(rst), .headValid(headValid), .headInstr(headInstr), .headPc(headPc),
    .pop(pop), .advance(advance), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .dx(dx)
  );

  decodeExReg stageReg0 (.Clk(Clk), .rst(rst), .advance(advance), .dx(dx));

  aluExecute alu0 (
    .Clk(Clk), .rst(rst), .dx(dx), .resCredit(resCredit), .advance(advance),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .resValid(resValid),
    .resDest(resDest), .resData(resData), .resPc(resPc)
  );

endmodule

// ==== dv/tbTop.sv ====
module tbTop;

  localparam int NumDirected   = 32;
  localparam int NumRandom     = 200;
  localparam int TimeoutCycles = 20 * (NumDirected + NumRandom) + 100;

  logic             Clk;
  logic             rst;
  logic             instrValid;
  mipsPkg::word_t   instr;
  mipsPkg::word_t   instrPc;
  logic             instrCredit;
  logic             resValid;
  mipsPkg::regIdx_t resDest;
  mipsPkg::word_t   resData;
  mipsPkg::word_t   resPc;
  logic             resCredit;

  logic [15:0]      lfsrState;
  mipsPkg::word_t   modelRegs [32];
  mipsPkg::regIdx_t expDest [$];
  mipsPkg::word_t   expData [$];
  mipsPkg::word_t   expPc [$];
  int               inCredits, outstanding, cycleCount, sentCount, recvCount;

  decodeExecTop dut0 (
    .Clk(Clk), .rst(rst), .instrValid(instrValid), .instr(instr), .instrPc(instrPc),
    .instrCredit(instrCredit), .resValid(resValid), .resDest(resDest), .resData(resData),
    .resPc(resPc), .resCredit(resCredit)
  );

  always #5 Clk = ~Clk;

  ////////////////////////////////////////
  // Error handling and compares
  ////////////////////////////////////////

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic compareIdx(input string name, input mipsPkg::regIdx_t got,
                            input mipsPkg::regIdx_t exp);
    if (got !== exp) begin
      failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compareWord(input string name, input mipsPkg::word_t got,
                             input mipsPkg::word_t exp);
    if (got !== exp) begin
      failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Galois LFSR, taps 0xB400, one step per bit taken
  function automatic logic [31:0] nextBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
      bits = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  ////////////////////////////////////////
  // Encoders and reference model
  ////////////////////////////////////////

  function automatic mipsPkg::word_t rType(input logic [5:0] fn, input mipsPkg::regIdx_t rs,
      input mipsPkg::regIdx_t rt, input mipsPkg::regIdx_t rd, input mipsPkg::shamt_t sh);
    return {mipsPkg::OpRType, rs, rt, rd, sh, fn};
  endfunction

  function automatic mipsPkg::word_t iType(input logic [5:0] op, input mipsPkg::regIdx_t rs,
      input mipsPkg::regIdx_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Expected record for one instruction against the model register file
  function automatic void predict(input mipsPkg::word_t ins, output mipsPkg::regIdx_t dest,
                                  output mipsPkg::word_t data);
    mipsPkg::word_t a, b;
    logic [15:0]    imm;
    a    = modelRegs[ins[25:21]];
    b    = modelRegs[ins[20:16]];
    imm  = ins[15:0];
    dest = ins[20:16];
    data = '0;
    case (ins[31:26])
      mipsPkg::OpRType: begin
        dest = ins[15:11];
        case (ins[5:0])
          mipsPkg::FnAdd: data = a + b;
          mipsPkg::FnSub: data = a - b;
          mipsPkg::FnAnd: data = a & b;
          mipsPkg::FnOr:  data = a | b;
          mipsPkg::FnSlt: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mipsPkg::FnSll: data = b << ins[10:6];
          mipsPkg::FnSrl: data = b >> ins[10:6];
          default:        dest = '0;
        endcase
      end
      mipsPkg::OpAddi: data = a + {{16{imm[15]}}, imm};
      mipsPkg::OpAndi: data = a & {16'h0000, imm};
      mipsPkg::OpOri:  data = a | {16'h0000, imm};
      mipsPkg::OpLui:  data = {imm, 16'h0000};
      default:         dest = '0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge Clk);
      #1;
    end
  endtask

  // Waits for an upstream credit, then sends one instruction
  task automatic sendInstr(input mipsPkg::word_t ins);
    mipsPkg::regIdx_t dest;
    mipsPkg::word_t   data;
    while (inCredits == 0) begin
      @(posedge Clk);
      #1;
    end
    instrValid = 1'b1;
    instr      = ins;
    inCredits--;
    predict(ins, dest, data);
    expDest.push_back(dest);
    expData.push_back(data);
    expPc.push_back(instrPc);
    if (dest != '0) modelRegs[dest] = data;
    sentCount++;
    @(posedge Clk);
    #1;
    instrValid = 1'b0;
    instrPc    = instrPc + 32'd4;
  endtask

  function automatic mipsPkg::word_t randomInstr();
    logic [3:0]       sel;
    mipsPkg::regIdx_t rs, rt, rd;
    sel = 4'(nextBits(4));
    // Small register window keeps dependences frequent
    rs = mipsPkg::regIdx_t'(nextBits(3));
    rt = mipsPkg::regIdx_t'(nextBits(3));
    rd = mipsPkg::regIdx_t'(nextBits(3));
    case (sel)
      4'd0:    return rType(mipsPkg::FnAdd, rs, rt, rd, 5'd0);
      4'd1:    return rType(mipsPkg::FnSub, rs, rt, rd, 5'd0);
      4'd2:    return rType(mipsPkg::FnAnd, rs, rt, rd, 5'd0);
      4'd3:    return rType(mipsPkg::FnOr, rs, rt, rd, 5'd0);
      4'd4:    return rType(mipsPkg::FnSlt, rs, rt, rd, 5'd0);
      4'd5:    return rType(mipsPkg::FnSll, rs, rt, rd, mipsPkg::shamt_t'(nextBits(5)));
      4'd6:    return rType(mipsPkg::FnSrl, rs, rt, rd, mipsPkg::shamt_t'(nextBits(5)));
      4'd7:    return iType(mipsPkg::OpAndi, rs, rt, 16'(nextBits(16)));
      4'd8:    return iType(mipsPkg::OpOri, rs, rt, 16'(nextBits(16)));
      4'd9:    return iType(mipsPkg::OpLui, rs, rt, 16'(nextBits(16)));
      // Load opcode and a bad funct, both unsupported
      4'd10:   return iType(6'h23, rs, rt, 16'(nextBits(16)));
      4'd11:   return rType(6'h3f, rs, rt, rd, 5'd0);
      default: return iType(mipsPkg::OpAddi, rs, rt, 16'(nextBits(16)));
    endcase
  endfunction

  initial begin
    Clk         = 1'b0;
    rst         = 1'b1;
    instrValid  = 1'b0;
    instr       = '0;
    instrPc     = 32'h0040_0000;
    resCredit   = 1'b0;
    lfsrState   = 16'd68;
    inCredits   = mipsPkg::QueueDepth;
    outstanding = 0;
    cycleCount  = 0;
    sentCount   = 0;
    recvCount   = 0;
    for (int i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
    end
    repeat (4) @(posedge Clk);
    #1;
    rst = 1'b0;
    // Quiet period, the monitor flags any stray pulse
    idleCycles(8);
    // Every register reads zero after reset
    for (int k = 0; k < 16; k++) begin
      sendInstr(rType(mipsPkg::FnOr, mipsPkg::regIdx_t'(2 * k),
                      mipsPkg::regIdx_t'(2 * k + 1), 5'd1, 5'd0));
    end
    // Directed ops, back to back and mostly dependent
    sendInstr(iType(mipsPkg::OpLui, 5'd0, 5'd1, 16'h8001));
    sendInstr(iType(mipsPkg::OpOri, 5'd1, 5'd1, 16'hf00f));
    sendInstr(iType(mipsPkg::OpAddi, 5'd0, 5'd2, 16'hfffb));
    sendInstr(iType(mipsPkg::OpAndi, 5'd1, 5'd3, 16'hff0f));
    sendInstr(rType(mipsPkg::FnAdd, 5'd1, 5'd2, 5'd4, 5'd0));
    sendInstr(rType(mipsPkg::FnSub, 5'd2, 5'd1, 5'd5, 5'd0));
    sendInstr(rType(mipsPkg::FnAnd, 5'd1, 5'd2, 5'd6, 5'd0));
    sendInstr(rType(mipsPkg::FnOr, 5'd1, 5'd3, 5'd7, 5'd0));
    sendInstr(rType(mipsPkg::FnSlt, 5'd2, 5'd1, 5'd8, 5'd0));
    sendInstr(rType(mipsPkg::FnSlt, 5'd1, 5'd2, 5'd9, 5'd0));
    sendInstr(rType(mipsPkg::FnSll, 5'd0, 5'd1, 5'd10, 5'd4));
    sendInstr(rType(mipsPkg::FnSrl, 5'd0, 5'd1, 5'd11, 5'd7));
    sendInstr(iType(mipsPkg::OpAddi, 5'd1, 5'd0, 16'h1234));
    sendInstr(rType(mipsPkg::FnAdd, 5'd0, 5'd0, 5'd12, 5'd0));
    sendInstr(iType(6'h23, 5'd1, 5'd13, 16'h0004));
    sendInstr(rType(6'h3f, 5'd1, 5'd2, 5'd14, 5'd0));
    for (int n = 0; n < NumRandom; n++) begin
      if (nextBits(2) == 0) idleCycles(int'(nextBits(2)) + 1);
      sendInstr(randomInstr());
    end
    while (recvCount < sentCount) @(negedge Clk);
    idleCycles(4);
    // Every queue entry has been popped once the last record is back
    if (inCredits != mipsPkg::QueueDepth) begin
      failRun($sformatf("Upstream holds %0d of %0d instruction credits at the end",
                        inCredits, mipsPkg::QueueDepth));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Downstream, monitor and timeout
  ////////////////////////////////////////

  // Sparse credit return, offset from the instruction driver
  // so the shared LFSR is stepped in a fixed order
  always begin
    @(posedge Clk);
    #2;
    if (!rst && outstanding > 0 && nextBits(2) == 0) begin
      resCredit = 1'b1;
      outstanding--;
    end else begin
      resCredit = 1'b0;
    end
  end

  always @(negedge Clk) begin
    if (!rst) begin
      if (instrCredit) begin
        if (inCredits >= mipsPkg::QueueDepth) failRun("Instruction credit returned with none owed");
        inCredits++;
      end
      if (resValid) begin
        if (expDest.size() == 0) failRun("Result record arrived with none expected");
        outstanding++;
        if (outstanding > mipsPkg::ResCreditMax) failRun("Result sent without a downstream credit");
        compareIdx("resDest", resDest, expDest.pop_front());
        compareWord("resData", resData, expData.pop_front());
        compareWord("resPc", resPc, expPc.pop_front());
        recvCount++;
      end
    end
  end

  always @(posedge Clk) begin
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      failRun($sformatf("Timeout after %0d cycles with %0d of %0d records received",
                        cycleCount, recvCount, sentCount));
    end
  end

endmodule

// ==== vlog.f ====
src/mipsPkg.sv
src/decodeExIf.sv
src/instrQueue.sv
src/instrDecoder.sv
src/decodeExReg.sv
src/aluExecute.sv
src/decodeExecTop.sv
dv/tbTop.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the decode/execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --top-module tbTop -f vlog.f -o simTb; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ "$simStatus" -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

exit 0
